//--- tb.f
logic/a53_bus_pkg.sv
logic/a53_mapper_pkg.sv
logic/a53_write_decode.sv
logic/a53_bank_regs.sv
logic/a53_prg_map.sv
logic/a53_ppu_map.sv
logic/a53_top.sv
bench/tb_clock.sv
bench/a53_props.sv
bench/a53_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the Action 53 mapper testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module a53_tb -Mdir obj_dir -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Let the bench report assertion failures itself instead of stopping at the first one
output=$(./obj_dir/Va53_tb +verilator+error+limit+100 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- bench/a53_tb.sv
// ****************************************
// Action 53 mapper bench, model checked every falling edge
// Stops at the first mismatch
// ****************************************
`timescale 1ns/1ps

module a53_tb
	import a53_bus_pkg::*, a53_mapper_pkg::*;
();

	logic              clk;
	logic              rst;
	logic              ce;
	mapper_id_t        mapper_id;
	logic              mirror_vertical;
	logic              chr_ram;
	logic [CPU_AW-1:0] prg_ain;
	logic              prg_write;
	logic [DATA_W-1:0] prg_din;
	logic [PPU_AW-1:0] chr_ain;
	logic [MEM_AW-1:0] prg_aout;
	logic              prg_allow;
	logic              prg_open_bus;
	logic [MEM_AW-1:0] chr_aout;
	logic              chr_allow;
	logic              vram_a10;
	logic              vram_ce;

	// Bench model of the register state
	bank_size_t m_size;
	prg_mode_t  m_mode;
	mirror_t    m_mirror;
	reg_sel_t   m_sel;
	logic [5:0] m_outer;
	logic [3:0] m_inner;
	logic [1:0] m_chr;

	int          seed;
	logic [31:0] rnd;
	logic        check_on;          // Compare enabled outside reset
	string       test_name;

	tb_clock clock_i (.clk(clk));

	a53_top dut_i (
		.clk(clk), .rst(rst), .ce(ce), .mapper_id(mapper_id),
		.mirror_vertical(mirror_vertical), .chr_ram(chr_ram),
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_din(prg_din), .chr_ain(chr_ain),
		.prg_aout(prg_aout), .prg_allow(prg_allow), .prg_open_bus(prg_open_bus),
		.chr_aout(chr_aout), .chr_allow(chr_allow), .vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	// 16K bank number built from size index s, then wrapped to 32 banks
	function automatic logic [MEM_AW-1:0] ref_prg_addr(input logic [CPU_AW-1:0] a,
			input bank_size_t sz, input prg_mode_t pm,
			input logic [5:0] out_b, input logic [3:0] in_b);
		int   s;
		int   bank;
		logic switch_half;
		s = int'(sz);
		switch_half = (pm == PM_UNROM_HI) ? ~a[14] : a[14];
		if (pm == PM_NROM)
			bank = (((int'(out_b) >> s) << s) | (int'(in_b) & ((1 << s) - 1))) * 2 + int'(a[14]);
		else if (switch_half)
			bank = ((int'(out_b) >> s) << (s + 1)) | (int'(in_b) & ((2 << s) - 1));
		else
			bank = int'(out_b) * 2 + int'(a[14]);   // Fixed half
		ref_prg_addr = MEM_AW'((bank % 32) * 16384 + int'(a[13:0]));
	endfunction

	function automatic logic [MEM_AW-1:0] ref_chr_addr(input logic [PPU_AW-1:0] a,
			input logic [1:0] bank);
		ref_chr_addr = MEM_AW'(int'(CHR_RAM_BASE) * 32768 + int'(bank) * 8192 + int'(a[12:0]));
	endfunction

	function automatic logic ref_vram_a10(input logic [PPU_AW-1:0] a, input mirror_t mir);
		case (mir)
			MIR_ONE_LO: ref_vram_a10 = 1'b0;
			MIR_ONE_HI: ref_vram_a10 = 1'b1;
			MIR_VERT:   ref_vram_a10 = a[10];
			default:    ref_vram_a10 = a[11];
		endcase
	endfunction

	// Hand computed reads at $8000 or $C000 right after reset
	function automatic logic [MEM_AW-1:0] preset_addr(input mapper_id_t map, input logic hi);
		case (map)
			MAP_UNROM: preset_addr = hi ? 22'h07C000 : 22'h040000;
			MAP_AXROM: preset_addr = hi ? 22'h004000 : 22'h000000;
			default:   preset_addr = hi ? 22'h07C000 : 22'h078000;
		endcase
	endfunction

	function automatic mapper_id_t map_of(input int k);
		case (k)
			0:       map_of = MAP_NROM;
			1:       map_of = MAP_UNROM;
			2:       map_of = MAP_AXROM;
			default: map_of = MAP_A53;
		endcase
	endfunction

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_addr(input string name, input logic [MEM_AW-1:0] exp,
			input logic [MEM_AW-1:0] act);
		if (act !== exp)
			fail_stop($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_a10(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
	endtask

	// Register model, same edges as the DUT
	always @(posedge clk) begin
		if (rst) begin
			m_size   <= (mapper_id == MAP_UNROM || mapper_id == MAP_AXROM) ? SZ_256K : SZ_32K;
			m_mode   <= (mapper_id == MAP_UNROM) ? PM_UNROM_HI : PM_NROM;
			m_outer  <= (mapper_id == MAP_AXROM) ? 6'h00 : OUTER_RESET;
			m_inner  <= 4'h0;
			m_chr    <= 2'b00;
			m_sel    <= SEL_INNER;
			if (mapper_id == MAP_AXROM)
				m_mirror <= MIR_ONE_LO;
			else
				m_mirror <= mirror_vertical ? MIR_VERT : MIR_HORIZ;
		end else if (ce && prg_write) begin
			if (prg_ain[15:12] == 4'h5 && mapper_id == MAP_A53)
				m_sel <= reg_sel_t'({prg_din[7], prg_din[0]});    // D7 high, D0 low
			if (prg_ain[15]) begin
				if (m_sel == SEL_CHR)
					m_chr <= prg_din[1:0];
				if (m_sel == SEL_INNER)
					m_inner <= prg_din[3:0];
				if (m_sel == SEL_OUTER)
					m_outer <= prg_din[5:0];
				if ((m_sel == SEL_CHR || m_sel == SEL_INNER) &&
				    (m_mirror == MIR_ONE_LO || m_mirror == MIR_ONE_HI))
					m_mirror <= prg_din[4] ? MIR_ONE_HI : MIR_ONE_LO;   // Page pick
				if (m_sel == SEL_MODE) begin
					m_mirror <= mirror_t'(prg_din[1:0]);
					m_size   <= bank_size_t'(prg_din[5:4]);
					if (!prg_din[3])
						m_mode <= PM_NROM;                  // Codes 00 and 01
					else
						m_mode <= prg_din[2] ? PM_UNROM_HI : PM_UNROM_LO;
				end
			end
		end
	end

	// Compare every output against the model, mid cycle
	always @(negedge clk) begin
		// Bus rules hold through reset as well
		check_flag({test_name, " prg_allow"}, prg_ain[15] && !prg_write, prg_allow);
		check_flag({test_name, " vram_ce"}, chr_ain[13], vram_ce);
		if (check_on) begin
			check_addr({test_name, " prg_aout"},
				ref_prg_addr(prg_ain, m_size, m_mode, m_outer, m_inner), prg_aout);
			check_addr({test_name, " chr_aout"}, ref_chr_addr(chr_ain, m_chr), chr_aout);
			check_a10({test_name, " vram_a10"}, ref_vram_a10(chr_ain, m_mirror), vram_a10);
			check_flag({test_name, " prg_open_bus"},
				mapper_id == MAP_AXROM && prg_ain[15:13] == 3'b011, prg_open_bus);
			check_flag({test_name, " chr_allow"}, chr_ram, chr_allow);
		end
	end

	task automatic wait_clock_start();
		int n;
		n = 0;
		while (clk !== 1'b1 && n < 100) begin
			#1;
			n++;
		end
		if (clk !== 1'b1)
			fail_stop("Clock did not start within 100 ns");
	endtask

	task automatic apply_reset(input mapper_id_t map, input logic mv);
		@(posedge clk);
		check_on = 1'b0;
		mapper_id       <= map;
		mirror_vertical <= mv;
		chr_ram         <= ~mv;
		rst             <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		check_on = 1'b1;
	endtask

	task automatic bus_write(input logic [CPU_AW-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge clk);
		ce        <= 1'b1;
		prg_write <= 1'b1;
		prg_ain   <= addr;
		prg_din   <= data;
		@(posedge clk);                 // Taken on this edge
		ce        <= 1'b0;
		prg_write <= 1'b0;
	endtask

	// Write cycle with the bus strobe held low
	task automatic idle_write(input logic [CPU_AW-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge clk);
		ce        <= 1'b0;
		prg_write <= 1'b1;
		prg_ain   <= addr;
		prg_din   <= data;
		@(posedge clk);
		prg_write <= 1'b0;
	endtask

	task automatic bus_read(input logic [CPU_AW-1:0] addr, input logic [PPU_AW-1:0] caddr);
		@(posedge clk);
		prg_ain <= addr;
		chr_ain <= caddr;
		@(negedge clk);                 // Outputs settled here
	endtask

	task automatic random_reads(input int count);
		logic [31:0] r;
		int          n;
		for (n = 0; n < count; n++) begin
			r = $random(seed);
			bus_read(r[15:0], r[29:16]);
		end
	endtask

	initial begin
		int i;
		int k;
		seed = 63;
		check_on = 1'b0;
		test_name = "init";
		rst             <= 1'b1;
		ce              <= 1'b0;
		mapper_id       <= MAP_NROM;
		mirror_vertical <= 1'b0;
		chr_ram         <= 1'b1;
		prg_ain         <= '0;
		prg_write       <= 1'b0;
		prg_din         <= '0;
		chr_ain         <= '0;
		wait_clock_start();

		test_name = "presets";
		for (i = 0; i < 8; i++) begin
			apply_reset(map_of(i % 4), i >= 4);
			bus_read(16'h8000, 14'h2400);
			check_addr("presets $8000", preset_addr(map_of(i % 4), 1'b0), prg_aout);
			bus_read(16'hC000, 14'h2800);
			check_addr("presets $C000", preset_addr(map_of(i % 4), 1'b1), prg_aout);
			random_reads(4);
		end

		test_name = "unrom";
		apply_reset(MAP_UNROM, 1'b0);
		for (i = 0; i < 12; i++) begin
			rnd = $random(seed);
			bus_write({1'b1, rnd[14:0]}, rnd[23:16]);
			bus_read({2'b11, rnd[29:16]}, rnd[13:0]);
			check_addr("unrom fixed $C000", MEM_AW'(31 * 16384 + int'(rnd[29:16])), prg_aout);
			bus_read({2'b10, rnd[29:16]}, rnd[13:0]);
		end

		// Every size and mode code, outer and inner random
		test_name = "a53 sweep";
		apply_reset(MAP_A53, 1'b1);
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			bus_write(16'h5000, 8'h80);
			bus_write(16'h8000, {2'b00, 2'(i / 4), 2'(i % 4), rnd[1:0]});
			bus_write(16'h5FFF, 8'h81);
			bus_write(16'hFFFF, rnd[15:8]);
			bus_write(16'h5000, 8'h01);
			bus_write(16'hC000, rnd[23:16]);
			bus_read({2'b10, rnd[29:16]}, rnd[13:0]);
			bus_read({2'b11, rnd[29:16]}, rnd[13:0]);
			random_reads(2);
		end

		test_name = "mirroring";
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			bus_write(16'h5000, 8'h80);
			bus_write(16'h8000, {6'b000000, 2'(i % 4)});
			bus_write(16'h5000, 8'h00);     // CHR
			bus_write(16'h8000, rnd[7:0]);
			random_reads(2);
			bus_write(16'h5000, 8'h01);     // Inner
			bus_write(16'h8000, rnd[15:8]);
			random_reads(2);
		end

		// Inner drives the $8000 half here, so a stray write shows up
		test_name = "ce low";
		bus_write(16'h5000, 8'h80);
		bus_write(16'h8000, 8'h3E);         // 256K, $8000 switches, vertical
		bus_write(16'h5000, 8'h01);
		for (i = 0; i < 6; i++) begin
			rnd = $random(seed);
			idle_write({1'b1, rnd[14:0]}, rnd[23:16]);
			idle_write(16'h5000, {1'b1, rnd[30:25], 1'b0});    // Mode select if taken
			bus_read({2'b10, rnd[29:16]}, rnd[13:0]);
			bus_write(16'h8000, rnd[7:0]);
			random_reads(1);
		end

		// Mapper 2 drops the select write, bank write still hits inner
		test_name = "select ignored";
		apply_reset(MAP_UNROM, 1'b1);
		rnd = $random(seed);
		bus_write(16'h5000, 8'h80);
		bus_write(16'h8000, rnd[7:0]);
		bus_read(16'h8000, 14'h0000);
		check_addr("select ignored $8000", MEM_AW'((16 + int'(rnd[3:0])) * 16384), prg_aout);

		test_name = "open bus";
		for (i = 0; i < 4; i++) begin
			apply_reset(map_of(i), 1'b0);
			for (k = 0; k < 6; k++) begin
				rnd = $random(seed);
				bus_read({3'b011, rnd[12:0]}, rnd[29:16]);
				check_flag("open bus window", map_of(i) == MAP_AXROM, prg_open_bus);
				bus_read(rnd[15:0], rnd[29:16]);
			end
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- bench/a53_props.sv
// ****************************************
// Bound checks on a53_top outputs, sampled on rising clk
// ****************************************
`timescale 1ns/1ps

module a53_props
	import a53_bus_pkg::*;
(
	input logic              clk,
	input logic              prg_write,
	input logic              prg_allow,
	input logic [PPU_AW-1:0] chr_ain,
	input logic              vram_ce,
	input logic [MEM_AW-1:0] chr_aout
);

	// ROM never drives the bus on a CPU write
	a_no_allow_on_write: assert property (@(posedge clk) prg_write |-> !prg_allow)
		else $error("prg_allow high during a CPU write");

	// Nametable space goes to CIRAM
	a_vram_ce: assert property (@(posedge clk) vram_ce == chr_ain[13])
		else $error("vram_ce differs from chr_ain bit 13");

	// CHR accesses stay in the CHR RAM region
	a_chr_prefix: assert property (@(posedge clk) chr_aout[MEM_AW-1 -: 7] == CHR_RAM_BASE)
		else $error("chr_aout outside the CHR RAM region");

endmodule

bind a53_top a53_props props_i (
	.clk(clk), .prg_write(prg_write), .prg_allow(prg_allow),
	.chr_ain(chr_ain), .vram_ce(vram_ce), .chr_aout(chr_aout)
);

//--- bench/tb_clock.sv
// ****************************************
// Free running bench clock, 40 ns period
// ****************************************
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;             // First rising edge at 20 ns

	always #20 clk = ~clk;          // 25 MHz

endmodule

//--- logic/a53_top.sv
// ****************************************
// Action 53 mapper, presets for mappers 0, 2, 7 and 28
// Cart levels must be stable while rst is high
// ****************************************
`timescale 1ns/1ps

module a53_top
	import a53_bus_pkg::*, a53_mapper_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              ce,              // CPU bus strobe
	input  mapper_id_t        mapper_id,
	input  logic              mirror_vertical,
	input  logic              chr_ram,         // Cart has writable CHR
	input  logic [CPU_AW-1:0] prg_ain,
	input  logic              prg_write,
	input  logic [DATA_W-1:0] prg_din,
	input  logic [PPU_AW-1:0] chr_ain,
	output logic [MEM_AW-1:0] prg_aout,
	output logic              prg_allow,
	output logic              prg_open_bus,
	output logic [MEM_AW-1:0] chr_aout,
	output logic              chr_allow,
	output logic              vram_a10,
	output logic              vram_ce
);

	reg_sel_t   sel;
	logic       bank_wr;
	bank_size_t size;
	prg_mode_t  prg_mode;
	mirror_t    mirror;
	logic [5:0] outer;
	logic [3:0] inner;
	logic [1:0] chr_bank;

	a53_write_decode decode_i (
		.clk(clk), .rst(rst), .ce(ce), .mapper_id(mapper_id),
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_din(prg_din),
		.sel(sel), .bank_wr(bank_wr), .sel_valid()
	);

	a53_bank_regs regs_i (
		.clk(clk), .rst(rst), .mapper_id(mapper_id), .mirror_vertical(mirror_vertical),
		.bank_wr(bank_wr), .sel(sel), .prg_din(prg_din),
		.size(size), .prg_mode(prg_mode), .mirror(mirror),
		.outer(outer), .inner(inner), .chr_bank(chr_bank)
	);

	a53_prg_map prg_i (
		.mapper_id(mapper_id), .size(size), .prg_mode(prg_mode),
		.outer(outer), .inner(inner), .prg_ain(prg_ain), .prg_write(prg_write),
		.prg_aout(prg_aout), .prg_allow(prg_allow), .prg_open_bus(prg_open_bus)
	);

	a53_ppu_map ppu_i (
		.mirror(mirror), .chr_bank(chr_bank), .chr_ain(chr_ain),
		.chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	assign chr_allow = chr_ram;    // CHR writes only with RAM fitted

endmodule

//--- logic/a53_ppu_map.sv
// ****************************************
// CHR RAM banking and nametable mirroring
// ****************************************
`timescale 1ns/1ps

module a53_ppu_map
	import a53_bus_pkg::*, a53_mapper_pkg::*;
(
	input  mirror_t           mirror,
	input  logic [1:0]        chr_bank,
	input  logic [PPU_AW-1:0] chr_ain,
	output logic [MEM_AW-1:0] chr_aout,
	output logic              vram_a10,
	output logic              vram_ce
);

	// 32K of CHR RAM as four 8K pages
	assign chr_aout = {CHR_RAM_BASE, chr_bank, chr_ain[12:0]};

	// CIRAM A10 per mirroring
	always_comb begin
		case (mirror)
			MIR_ONE_LO: vram_a10 = 1'b0;          // Lower page only
			MIR_ONE_HI: vram_a10 = 1'b1;          // Upper page only
			MIR_VERT:   vram_a10 = chr_ain[10];
			default:    vram_a10 = chr_ain[11];   // Horizontal
		endcase
	end

	assign vram_ce = chr_ain[13];                 // $2000-$3FFF goes to CIRAM

endmodule

//--- logic/a53_prg_map.sv
// ****************************************
// PRG ROM address from bank registers, 512K of ROM reachable
// ****************************************
`timescale 1ns/1ps

module a53_prg_map
	import a53_bus_pkg::*, a53_mapper_pkg::*;
(
	input  mapper_id_t        mapper_id,
	input  bank_size_t        size,
	input  prg_mode_t         prg_mode,
	input  logic [5:0]        outer,
	input  logic [3:0]        inner,
	input  logic [CPU_AW-1:0] prg_ain,
	input  logic              prg_write,
	output logic [MEM_AW-1:0] prg_aout,
	output logic              prg_allow,
	output logic              prg_open_bus
);

	logic [5:0] inner_mask;   // Outer bits replaced by inner
	logic [6:0] nrom_bank;    // 16K bank number, 32K mode
	logic [6:0] switch_bank;  // Switchable half of UNROM
	logic [6:0] fixed_bank;   // Fixed half of UNROM
	logic [6:0] bank;

	// Larger outer span gives inner more bits
	always_comb begin
		case (size)
			SZ_32K:  inner_mask = 6'b000000;
			SZ_64K:  inner_mask = 6'b000001;
			SZ_128K: inner_mask = 6'b000011;
			default: inner_mask = 6'b000111;
		endcase
	end

	assign nrom_bank   = {(outer & ~inner_mask) | ({2'b00, inner} & inner_mask), prg_ain[14]};
	// UNROM takes one more inner bit in place of A14
	assign switch_bank = ({outer, 1'b0} & ~{inner_mask, 1'b1}) |
	                     ({3'b000, inner} & {inner_mask, 1'b1});
	assign fixed_bank  = {outer, prg_ain[14]};

	always_comb begin
		case (prg_mode)
			PM_UNROM_LO: bank = prg_ain[14] ? switch_bank : fixed_bank;
			PM_UNROM_HI: bank = prg_ain[14] ? fixed_bank : switch_bank;
			default:     bank = nrom_bank;
		endcase
	end

	// Top bank bits dropped, ROM limited to 32 banks of 16K
	assign prg_aout = {{(MEM_AW - PRG_BANK_W - 14){1'b0}}, bank[PRG_BANK_W-1:0], prg_ain[13:0]};

	assign prg_allow = prg_ain[15] & ~prg_write;   // ROM is read only

	// AxROM boards leave $6000-$7FFF floating
	assign prg_open_bus = (prg_ain[15:13] == WRAM_WIN) && (mapper_id == MAP_AXROM);

endmodule

//--- logic/a53_bank_regs.sv
// ****************************************
// Mode, outer, inner and CHR bank registers
// mapper_id and mirror_vertical are sampled only during rst
// ****************************************
`timescale 1ns/1ps

module a53_bank_regs
	import a53_bus_pkg::*, a53_mapper_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  mapper_id_t        mapper_id,
	input  logic              mirror_vertical,  // Cart solder pad
	input  logic              bank_wr,
	input  reg_sel_t          sel,
	input  logic [DATA_W-1:0] prg_din,
	output bank_size_t        size,
	output prg_mode_t         prg_mode,
	output mirror_t           mirror,
	output logic [5:0]        outer,
	output logic [3:0]        inner,
	output logic [1:0]        chr_bank
);

	logic    one_screen;
	mirror_t page_sel;

	// D4 of CHR and inner writes picks the page in one-screen mode
	assign one_screen = (mirror == MIR_ONE_LO) || (mirror == MIR_ONE_HI);
	assign page_sel   = prg_din[4] ? MIR_ONE_HI : MIR_ONE_LO;

	always_ff @(posedge clk) begin
		if (rst) begin
			size     <= SZ_32K;                 // 32K NROM by default
			prg_mode <= PM_NROM;
			outer    <= OUTER_RESET;
			inner    <= '0;
			chr_bank <= '0;
			mirror   <= mirror_vertical ? MIR_VERT : MIR_HORIZ;
			case (mapper_id)
				MAP_UNROM: begin
					size     <= SZ_256K;        // Switch $8000, last bank at $C000
					prg_mode <= PM_UNROM_HI;
				end
				MAP_AXROM: begin
					size     <= SZ_256K;        // 32K banks picked by inner
					prg_mode <= PM_NROM;
					mirror   <= MIR_ONE_LO;     // Page set by writes
					outer    <= '0;
				end
				default: begin
				end
			endcase
		end else if (bank_wr) begin
			case (sel)
				SEL_CHR: begin
					chr_bank <= prg_din[1:0];   // 8K CHR RAM page
					if (one_screen)
						mirror <= page_sel;
				end
				SEL_INNER: begin
					inner <= prg_din[3:0];
					if (one_screen)
						mirror <= page_sel;
				end
				SEL_MODE: begin
					mirror   <= mirror_t'(prg_din[1:0]);
					// Fold code 01 into plain NROM
					prg_mode <= prg_din[3] ? prg_mode_t'(prg_din[3:2]) : PM_NROM;
					size     <= bank_size_t'(prg_din[5:4]);
				end
				SEL_OUTER: begin
					outer <= prg_din[5:0];      // 32K granularity
				end
				default: begin
				end
			endcase
		end
	end

endmodule

//--- logic/a53_write_decode.sv
// ****************************************
// CPU write decode, select register only loads for mapper 28
// ****************************************
`timescale 1ns/1ps

module a53_write_decode
	import a53_bus_pkg::*, a53_mapper_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              ce,          // CPU bus strobe
	input  mapper_id_t        mapper_id,
	input  logic [CPU_AW-1:0] prg_ain,
	input  logic              prg_write,
	input  logic [DATA_W-1:0] prg_din,
	output reg_sel_t          sel,         // Current register selector
	output logic              bank_wr,     // Write to $8000-$FFFF this edge
	output logic              sel_valid    // $5xxx write dropped, wrong mapper
);

	logic wr_accept;
	logic sel_hit;
	logic sel_allow;

	assign wr_accept = ce & prg_write;                          // Counts on this clk edge
	assign sel_hit   = wr_accept & (prg_ain[15:12] == SEL_WIN); // $5000-$5FFF
	assign sel_allow = (mapper_id == MAP_A53);                  // Only real Action 53 carts

	// Selector bits come from D7 and D0
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= SEL_INNER;                                   // Plain UNROM style bank writes
		end else if (sel_hit && sel_allow) begin
			sel <= reg_sel_t'({prg_din[7], prg_din[0]});
		end
	end

	// Bank regs sample on the same edge, so old sel applies
	assign bank_wr = wr_accept & prg_ain[15];

	assign sel_valid = sel_hit & ~sel_allow;                    // Observation only

endmodule

//--- logic/a53_mapper_pkg.sv
// ****************************************
// Mapper identity and register field encodings
// Field codes follow the Action 53 register layout
// ****************************************
package a53_mapper_pkg;

	// iNES mapper numbers this logic can stand in for
	typedef enum logic [7:0] {
		MAP_NROM  = 8'd0,
		MAP_UNROM = 8'd2,
		MAP_AXROM = 8'd7,
		MAP_A53   = 8'd28
	} mapper_id_t;

	// Target of a $8000-$FFFF write, from select bits {7,0}
	typedef enum logic [1:0] {
		SEL_CHR   = 2'b00,
		SEL_INNER = 2'b01,
		SEL_MODE  = 2'b10,
		SEL_OUTER = 2'b11
	} reg_sel_t;

	// Outer bank span
	typedef enum logic [1:0] {
		SZ_32K  = 2'b00,
		SZ_64K  = 2'b01,
		SZ_128K = 2'b10,
		SZ_256K = 2'b11
	} bank_size_t;

	// Code 01 also means NROM and is folded into 00 on load
	typedef enum logic [1:0] {
		PM_NROM     = 2'b00,    // 32K switched as a whole
		PM_UNROM_LO = 2'b10,    // $8000 fixed, $C000 switches
		PM_UNROM_HI = 2'b11     // $8000 switches, $C000 fixed
	} prg_mode_t;

	// Nametable mirroring
	typedef enum logic [1:0] {
		MIR_ONE_LO = 2'b00,
		MIR_ONE_HI = 2'b01,
		MIR_VERT   = 2'b10,
		MIR_HORIZ  = 2'b11
	} mirror_t;

	localparam logic [5:0] OUTER_RESET = 6'h3F;    // Last 32K of the ROM

endpackage

//--- logic/a53_bus_pkg.sv
// ****************************************
// Bus widths and window constants for the Action 53 mapper
// Memory map assumes CHR RAM sits above PRG ROM in one 4 MB space
// ****************************************
package a53_bus_pkg;

	// Address and data widths
	localparam int CPU_AW     = 16;         // CPU address bus
	localparam int PPU_AW     = 14;         // PPU address bus
	localparam int MEM_AW     = 22;         // External memory address
	localparam int DATA_W     = 8;          // CPU data bus

	// CPU windows
	localparam logic [3:0] SEL_WIN  = 4'h5;     // $5000-$5FFF select register
	localparam logic [2:0] WRAM_WIN = 3'b011;   // $6000-$7FFF, no WRAM fitted

	// Output address fields
	localparam int PRG_BANK_W = 5;          // 16K banks, 512K of PRG ROM
	localparam logic [6:0] CHR_RAM_BASE = 7'b1000000;  // Upper bits of CHR RAM region

endpackage
